// File: Bender.yml
package:
  name: ifu

sources:
  - include_dirs:
      - include
    files:
      - rtl/ifu_pkg.sv
      - rtl/ifu_fetch_ctl.sv
      - rtl/ifu_fetch_buf.sv
      - rtl/ifu_aligner.sv
      - rtl/ifu_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - testbench/tb_ifu.sv

// File: compile.f
+incdir+include
rtl/ifu_pkg.sv
rtl/ifu_fetch_ctl.sv
rtl/ifu_fetch_buf.sv
rtl/ifu_aligner.sv
rtl/ifu_top.sv
testbench/tb_ifu.sv

// File: include/ifu_cfg.svh
// Fetch unit build constants; buffer depth must be a power of two (2 to 16), pointer width its log2
`ifndef IFU_CFG_SVH
`define IFU_CFG_SVH

// ********************
// Reset fetch address
// ********************

// Byte address 0x100 in halfword pc form
`define IFU_RESET_VEC 31'h0000_0080

// ********************
// Fetch buffer sizing
// ********************

// Number of word entries
`define IFU_FB_DEPTH 4

// Log2 of IFU_FB_DEPTH, keep in step
`define IFU_FB_PTR_W 2

`endif

// File: rtl/ifu_aligner.sv
// Words after the first in a stream must start at the lower parcel; one instruction per cycle
module ifu_aligner
   import ifu_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  logic         exu_flush_final,        // Drops held parcel and output
   input  logic         fb_valid,
   input  word_t        fb_word,
   input  pc_t          fb_pc,                  // Bit 1 set skips lower parcel
   input  logic         dec_i0_decode_d,        // Decode takes the output
   output logic         fb_pop,
   output logic         ifu_i0_valid,
   output word_t        ifu_i0_instr,
   output pc_t          ifu_i0_pc,
   output logic         ifu_i0_pc4              // Low for compressed
);

   aln_state_t state, state_nxt;
   logic       used_lo, used_lo_nxt;            // Lower parcel of head taken
   parcel_t    part_parcel;                     // Lower half of straddler
   pc_t        part_pc;

   logic       ld_ok;                           // Output register free
   logic       step;
   logic       idx;                             // Current parcel in head word
   parcel_t    par;
   pc_t        par_pc;
   logic       is32;
   logic       emit, word_done, save_part;
   word_t      emit_instr;
   pc_t        emit_pc;
   logic       emit_pc4;

   // ********************
   // Parcel select
   // ********************

   assign ld_ok  = ~ifu_i0_valid | dec_i0_decode_d;
   assign step   = fb_valid & ld_ok & ~exu_flush_final;
   assign idx    = fb_pc[1] | used_lo;
   assign par    = idx ? fb_word[31:16] : fb_word[15:0];
   assign par_pc = {fb_pc[31:2], idx};
   assign is32   = (par[1:0] == 2'b11);       // Both low bits set

   always_comb begin
      emit        = 1'b0;
      emit_instr  = {16'h0000, par};            // Compressed, zero-extended
      emit_pc     = par_pc;
      emit_pc4    = 1'b0;
      word_done   = 1'b0;
      save_part   = 1'b0;
      state_nxt   = state;
      used_lo_nxt = used_lo;
      if (state == AL_PART) begin
         // Join held half with lower parcel of the new word
         emit        = 1'b1;
         emit_instr  = {fb_word[15:0], part_parcel};
         emit_pc     = part_pc;
         emit_pc4    = 1'b1;
         used_lo_nxt = 1'b1;
         state_nxt   = AL_EMPTY;
      end else if (!is32) begin
         emit        = 1'b1;
         word_done   = idx;                     // Upper parcel ends the word
         used_lo_nxt = ~idx;
      end else if (!idx) begin
         emit        = 1'b1;                    // Aligned 32-bit
         emit_instr  = fb_word;
         emit_pc4    = 1'b1;
         word_done   = 1'b1;
         used_lo_nxt = 1'b0;
      end else begin
         save_part   = 1'b1;                    // Straddles into next word
         state_nxt   = AL_PART;
         word_done   = 1'b1;
         used_lo_nxt = 1'b0;
      end
   end

   assign fb_pop = step & word_done;

   // ********************
   // Control state
   // ********************

   always_ff @(posedge clk) begin
      if (reset | exu_flush_final) begin
         state        <= AL_EMPTY;
         used_lo      <= 1'b0;
         ifu_i0_valid <= 1'b0;
      end else begin
         if (step) begin
            state   <= state_nxt;
            used_lo <= used_lo_nxt;
         end
         if (ld_ok) begin
            ifu_i0_valid <= step & emit;        // Held while decode stalls
         end
      end
   end

   // ********************
   // Payload registers
   // ********************

   always_ff @(posedge clk) begin
      if (step & emit) begin
         ifu_i0_instr <= emit_instr;
         ifu_i0_pc    <= emit_pc;
         ifu_i0_pc4   <= emit_pc4;
      end
      if (step & save_part) begin
         part_parcel <= par;
         part_pc     <= par_pc;
      end
   end

   // Stalled output keeps its instruction until decode takes it
   a_hold_stable : assert property (@(posedge clk) disable iff (reset)
      ifu_i0_valid && !dec_i0_decode_d && !exu_flush_final |=>
         ifu_i0_valid && $stable(ifu_i0_instr) && $stable(ifu_i0_pc) &&
         $stable(ifu_i0_pc4))
      else $error("aligner output changed while stalled");

endmodule

// File: rtl/ifu_fetch_buf.sv
// Depth must be a power of two; room means two free entries so a read in flight always fits
`include "ifu_cfg.svh"

module ifu_fetch_buf
   import ifu_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  logic         exu_flush_final,        // Empties the queue
   input  logic         fb_push,
   input  pc_t          fb_push_pc,             // Halfword start of the word
   input  word_t        imem_rd_data,
   input  logic         fb_pop,
   output logic         fb_valid,
   output word_t        fb_word,
   output pc_t          fb_pc,
   output logic        fb_room
);

   word_t                     mem_word [`IFU_FB_DEPTH];
   pc_t                       mem_pc   [`IFU_FB_DEPTH];
   logic [`IFU_FB_PTR_W-1:0]  wr_ptr;
   logic [`IFU_FB_PTR_W-1:0]  rd_ptr;
   fb_cnt_t                   cnt;

   // ********************
   // Storage
   // ********************

   always_ff @(posedge clk) begin
      if (fb_push & ~exu_flush_final) begin
         mem_word[wr_ptr] <= imem_rd_data;      // Data straight from memory
         mem_pc[wr_ptr]   <= fb_push_pc;
      end
   end

   // ********************
   // Pointers and count
   // ********************

   always_ff @(posedge clk) begin
      if (reset | exu_flush_final) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         cnt    <= '0;
      end else begin
         if (fb_push) begin
            wr_ptr <= wr_ptr + 1'b1;            // Wraps at depth
         end
         if (fb_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({fb_push, fb_pop})
            2'b10:   cnt <= cnt + fb_cnt_t'(1);
            2'b01:   cnt <= cnt - fb_cnt_t'(1);
            default: cnt <= cnt;                // Both or neither
         endcase
      end
   end

   // Head entry, visible the cycle after its push
   assign fb_valid = (cnt != '0);
   assign fb_word  = mem_word[rd_ptr];
   assign fb_pc    = mem_pc[rd_ptr];
   assign fb_room  = (cnt <= fb_cnt_t'(`IFU_FB_DEPTH - 2));

   // Fetch room check keeps the queue from overflowing
   a_no_overflow : assert property (@(posedge clk) disable iff (reset)
      fb_push && !exu_flush_final |-> cnt < fb_cnt_t'(`IFU_FB_DEPTH))
      else $error("push into a full fetch buffer");

   // Aligner pops only an entry it has seen
   a_no_underflow : assert property (@(posedge clk) disable iff (reset)
      fb_pop |-> fb_valid)
      else $error("pop from an empty fetch buffer");

endmodule

// File: rtl/ifu_fetch_ctl.sv
// Memory must return data exactly one cycle after imem_rd_en; only one read is ever in flight
`include "ifu_cfg.svh"

module ifu_fetch_ctl
   import ifu_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  logic         exu_flush_final,        // Redirect pulse
   input  pc_t          exu_flush_path_final,   // Redirect target
   input  logic         fb_room,                // Two or more free entries
   output logic         imem_rd_en,
   output pc_t          imem_rd_addr,           // Word address, bit 1 zero
   output logic         fb_push,
   output pc_t          fb_push_pc
);

   fetch_state_t state, state_nxt;
   pc_t          fetch_pc;                      // Next fetch, halfword exact
   logic         rd_pend;                       // Read issued last cycle

   // ********************
   // FSM
   // ********************

   always_comb begin
      state_nxt = state;
      case (state)
         FS_IDLE: state_nxt = FS_RUN;           // One dead cycle after reset
         FS_RUN: begin
            if (!fb_room) begin
               state_nxt = FS_HOLD;             // Back-pressure from buffer
            end
         end
         FS_HOLD: begin
            if (fb_room) begin
               state_nxt = FS_RUN;
            end
         end
         default: state_nxt = FS_IDLE;
      endcase
      if (exu_flush_final) begin
         state_nxt = FS_RUN;                    // Restart at new target
      end
   end

   // Read only with room for this word and the one in flight
   assign imem_rd_en   = (state == FS_RUN) & fb_room & ~exu_flush_final;
   assign imem_rd_addr = {fetch_pc[31:2], 1'b0};

   // ********************
   // Address and return tracking
   // ********************

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= FS_IDLE;
         fetch_pc <= `IFU_RESET_VEC;
         rd_pend  <= 1'b0;
      end else begin
         state   <= state_nxt;
         rd_pend <= imem_rd_en;                 // Strobe low in flush cycle
         if (exu_flush_final) begin
            fetch_pc <= exu_flush_path_final;   // May land on upper parcel
         end else if (imem_rd_en) begin
            fetch_pc <= {fetch_pc[31:2] + 30'd1, 1'b0}; // Next word, lower parcel
         end
      end
   end

   // Halfword start of the issued read rides along to the buffer
   always_ff @(posedge clk) begin
      if (imem_rd_en) begin
         fb_push_pc <= fetch_pc;
      end
   end

   assign fb_push = rd_pend & ~exu_flush_final; // Drop return that meets a flush

   // Emptied buffer lets the first read after a flush go straight to the target word
   a_flush_redirect : assert property (@(posedge clk) disable iff (reset)
      exu_flush_final ##1 !exu_flush_final |->
         imem_rd_en && imem_rd_addr == {$past(exu_flush_path_final[31:2]), 1'b0})
      else $error("fetch did not restart at the flush target");

endmodule

// File: rtl/ifu_pkg.sv
// Shared fetch unit types; pc values are halfword addresses held in bits 31 down to 1
`include "ifu_cfg.svh"

package ifu_pkg;

   // ********************
   // Datapath vectors
   // ********************

   typedef logic [31:1] pc_t;                   // Halfword program counter
   typedef logic [31:0] word_t;                 // One memory word
   typedef logic [15:0] parcel_t;               // One instruction parcel

   typedef logic [`IFU_FB_PTR_W:0] fb_cnt_t;    // Buffer occupancy, 0 to depth

   // ********************
   // FSM encodings
   // ********************

   typedef enum logic [1:0] {
      FS_IDLE,                                  // Out of reset, no reads yet
      FS_RUN,                                   // Issuing reads
      FS_HOLD                                   // Buffer lacks room
   } fetch_state_t;

   typedef enum logic {
      AL_EMPTY,                                 // No parcel held
      AL_PART                                   // Lower half of a straddler held
   } aln_state_t;

endpackage

// File: rtl/ifu_top.sv
// Reduced fetch unit; no prediction, cache or bus, memory must have a fixed one-cycle read latency
module ifu_top
   import ifu_pkg::*;
(
   input  logic         clk,
   input  logic         reset,                  // Synchronous, active high
   input  logic         exu_flush_final,
   input  pc_t          exu_flush_path_final,
   input  logic         dec_i0_decode_d,
   input  word_t        imem_rd_data,
   output logic         imem_rd_en,
   output pc_t          imem_rd_addr,
   output logic         ifu_i0_valid,
   output word_t        ifu_i0_instr,
   output pc_t          ifu_i0_pc,
   output logic         ifu_i0_pc4
);

   // ********************
   // Stage links
   // ********************

   logic  fb_push;                              // Fetch to buffer
   pc_t   fb_push_pc;
   logic  fb_room;
   logic  fb_valid;                             // Buffer to aligner
   word_t fb_word;
   pc_t   fb_pc;
   logic  fb_pop;

   ifu_fetch_ctl ifu_fetch_ctl_inst (
      .clk                  (clk),
      .reset                (reset),
      .exu_flush_final      (exu_flush_final),
      .exu_flush_path_final (exu_flush_path_final),
      .fb_room              (fb_room),
      .imem_rd_en           (imem_rd_en),
      .imem_rd_addr         (imem_rd_addr),
      .fb_push              (fb_push),
      .fb_push_pc           (fb_push_pc)
   );

   ifu_fetch_buf ifu_fetch_buf_inst (
      .clk                  (clk),
      .reset                (reset),
      .exu_flush_final      (exu_flush_final),
      .fb_push              (fb_push),
      .fb_push_pc           (fb_push_pc),
      .imem_rd_data         (imem_rd_data),     // Returned word, no staging
      .fb_pop               (fb_pop),
      .fb_valid             (fb_valid),
      .fb_word              (fb_word),
      .fb_pc                (fb_pc),
      .fb_room              (fb_room)
   );

   ifu_aligner ifu_aligner_inst (
      .clk                  (clk),
      .reset                (reset),
      .exu_flush_final      (exu_flush_final),
      .fb_valid             (fb_valid),
      .fb_word              (fb_word),
      .fb_pc                (fb_pc),
      .dec_i0_decode_d      (dec_i0_decode_d),
      .fb_pop               (fb_pop),
      .ifu_i0_valid         (ifu_i0_valid),
      .ifu_i0_instr         (ifu_i0_instr),
      .ifu_i0_pc            (ifu_i0_pc),
      .ifu_i0_pc4           (ifu_i0_pc4)
   );

endmodule

// File: testbench/tb_ifu.sv
// Memory model has a 1024-word image with one-cycle latency; the expected stream comes from the parcel rule
`include "ifu_cfg.svh"

module tb_ifu
   import ifu_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_INSTR    = 400;                    // All phases together
   localparam int MAX_CYCLES = N_INSTR * 4 * 2 + 800;  // Four cycles each, doubled, plus margin

   logic  clk = 1'b0;
   logic  reset;
   logic  exu_flush_final;
   pc_t   exu_flush_path_final;
   logic  dec_i0_decode_d;
   word_t imem_rd_data;
   logic  imem_rd_en;
   pc_t   imem_rd_addr;
   logic  ifu_i0_valid;
   word_t ifu_i0_instr;
   pc_t   ifu_i0_pc;
   logic  ifu_i0_pc4;

   word_t       imem [1024];
   logic [31:0] lcg_state = 32'hf9651b74;
   logic        rd_pend;                               // Read strobe seen last edge
   pc_t         rd_addr_q;
   int          n_acc = 0;
   int          err_value = 0;
   int          err_other = 0;
   int          cycle_cnt;
   string       test_name = "reset";

   ifu_top ifu_top_inst (.*);

   always #20 clk = ~clk;

   function logic [31:0] rand32();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // ********************
   // Memory model
   // ********************

   always @(posedge clk) begin
      rd_pend   <= imem_rd_en;
      rd_addr_q <= imem_rd_addr;
   end

   always @(negedge clk) begin
      if (rd_pend === 1'b1) begin
         imem_rd_data = imem[rd_addr_q[11:2]];         // Modulo 1024 words
      end
   end

   // ********************
   // Reference walk
   // ********************

   logic    accept;
   pc_t     ref_pc, ref_pc_hi;
   word_t   w_lo, w_hi;
   parcel_t p_lo, p_hi;
   word_t   exp_instr;
   logic    exp_pc4;
   logic    seen_any;                                  // First instruction accepted
   logic    post_flush;                                // Waiting for first after flush
   pc_t     flush_tgt;

   assign accept = ifu_i0_valid & dec_i0_decode_d & ~exu_flush_final;

   always_comb begin
      ref_pc_hi = ref_pc + pc_t'(1);
      w_lo      = imem[ref_pc[11:2]];
      w_hi      = imem[ref_pc_hi[11:2]];
      p_lo      = ref_pc[1] ? w_lo[31:16] : w_lo[15:0];
      p_hi      = ref_pc_hi[1] ? w_hi[31:16] : w_hi[15:0];
      exp_pc4   = (p_lo[1:0] == 2'b11);                // Low bits 11 start a 32-bit
      exp_instr = exp_pc4 ? {p_hi, p_lo} : {16'h0000, p_lo};
   end

   always @(posedge clk) begin
      if (reset) begin
         ref_pc     <= `IFU_RESET_VEC;
         seen_any   <= 1'b0;
         post_flush <= 1'b0;
      end else if (exu_flush_final) begin
         ref_pc     <= exu_flush_path_final;           // Jump with the flush
         flush_tgt  <= exu_flush_path_final;
         post_flush <= 1'b1;
      end else if (accept) begin
         ref_pc     <= ref_pc + (exp_pc4 ? pc_t'(2) : pc_t'(1));
         seen_any   <= 1'b1;
         post_flush <= 1'b0;
         n_acc      <= n_acc + 1;
      end
   end

   // ********************
   // Checks
   // ********************

   a_first_read : assert property (@(posedge clk) $fell(reset) |-> !imem_rd_en ##1 imem_rd_en)
      else begin
         err_other++;
         $display("First memory read did not come in the second cycle after reset");
      end

   a_first_pc : assert property (@(posedge clk) disable iff (reset)
      accept && !seen_any |-> ifu_i0_pc == `IFU_RESET_VEC)
      else begin
         err_value++;
         $display("ERR %s first_pc: expected %h, actual %h", test_name,
            `IFU_RESET_VEC, $sampled(ifu_i0_pc));
      end

   a_instr : assert property (@(posedge clk) disable iff (reset)
      accept |-> ifu_i0_instr == exp_instr)
      else begin
         err_value++;
         $display("ERR %s instr: expected %h, actual %h", test_name,
            $sampled(exp_instr), $sampled(ifu_i0_instr));
      end

   a_pc : assert property (@(posedge clk) disable iff (reset) accept |-> ifu_i0_pc == ref_pc)
      else begin
         err_value++;
         $display("ERR %s pc: expected %h, actual %h", test_name,
            $sampled(ref_pc), $sampled(ifu_i0_pc));
      end

   a_pc4 : assert property (@(posedge clk) disable iff (reset) accept |-> ifu_i0_pc4 == exp_pc4)
      else begin
         err_value++;
         $display("ERR %s pc4: expected %b, actual %b", test_name,
            $sampled(exp_pc4), $sampled(ifu_i0_pc4));
      end

   // Stalled output must not move or vanish
   a_hold : assert property (@(posedge clk) disable iff (reset)
      ifu_i0_valid && !dec_i0_decode_d && !exu_flush_final |=>
         ifu_i0_valid && $stable(ifu_i0_instr) && $stable(ifu_i0_pc) && $stable(ifu_i0_pc4))
      else begin
         err_other++;
         $display("Output changed or dropped while decode was stalled in %s", test_name);
      end

   a_flush_drop : assert property (@(posedge clk) disable iff (reset)
      exu_flush_final |=> !ifu_i0_valid)
      else begin
         err_other++;
         $display("Output still valid the cycle after a flush in %s", test_name);
      end

   a_flush_target : assert property (@(posedge clk) disable iff (reset)
      accept && post_flush |-> ifu_i0_pc == flush_tgt)
      else begin
         err_value++;
         $display("ERR %s flush_target: expected %h, actual %h", test_name,
            $sampled(flush_tgt), $sampled(ifu_i0_pc));
      end

   // ********************
   // Stimulus
   // ********************

   task automatic run_accepts(input int n, input bit stall);
      int          target;
      logic [31:0] r;
      target = n_acc + n;
      while (n_acc < target) begin
         @(negedge clk);
         r = rand32();
         dec_i0_decode_d = stall ? (r[31] | r[30]) : 1'b1; // Random low stretches
      end
   endtask

   function automatic pc_t odd_target();
      logic [31:0] r;
      r = rand32();
      return pc_t'(r[11:0]) | pc_t'(1);                // Upper parcel start
   endfunction

   task automatic flush_to(input pc_t tgt);
      @(negedge clk);
      exu_flush_final      = 1'b1;
      exu_flush_path_final = tgt;
      @(negedge clk);
      exu_flush_final      = 1'b0;
   endtask

   task automatic print_counts();
      $display("Errors: %0d value, %0d other, %0d instructions accepted",
         err_value, err_other, n_acc);
   endtask

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < MAX_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      err_other++;
      $display("Timeout after %0d cycles in %s", MAX_CYCLES, test_name);
      print_counts();
      $display("Verification failed");
      $finish;
   end

   initial begin
      reset                = 1'b1;
      exu_flush_final      = 1'b0;
      exu_flush_path_final = '0;
      dec_i0_decode_d      = 1'b0;
      imem_rd_data         = '0;
      for (int i = 0; i < 1024; i++) begin
         imem[i] = rand32();                           // Mixed compressed and 32-bit
      end
      repeat (3) @(negedge clk);
      reset = 1'b0;
      test_name = "reset_stream";
      run_accepts(100, 1'b0);
      test_name = "decode_stall";
      run_accepts(120, 1'b1);
      repeat (3) begin
         test_name = "flush_odd";
         flush_to(odd_target());
         run_accepts(30, 1'b1);
         test_name = "flush_full";
         @(negedge clk);
         dec_i0_decode_d = 1'b0;                       // Let the buffer fill
         repeat (16) @(negedge clk);
         flush_to(odd_target());
         run_accepts(30, 1'b1);
      end
      dec_i0_decode_d = 1'b0;
      repeat (4) @(negedge clk);
      print_counts();
      if (err_value == 0 && err_other == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule
